//--- files.f
hdl/rvv_pkg.sv
hdl/insn_issue.sv
hdl/vec_regfile.sv
hdl/vec_exec.sv
hdl/rvv_proc.sv
tests/rvv_proc_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= rvv_proc_tb
FILELIST  ?= files.f

.PHONY: sim clean

# pass only when the run prints the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

//--- tests/rvv_proc_tb.sv
`timescale 1ns/10ps

module rvv_proc_tb import rvv_pkg::*; ();
    localparam int NUM_INSN   = 120;                 // upper bound on instructions sent below
    localparam int MAX_CYCLES = 10 * NUM_INSN + 2;   // ten per instruction, plus reset

    logic            clk, rst_n;
    logic [31:0]     insn_in;
    logic            insn_valid;
    logic [XLEN-1:0] vexrv_data_in_1;
    logic            proc_rdy, mem_port_valid_out, vexrv_valid_out;
    logic [VLEN-1:0] mem_port_out;
    logic [XLEN-1:0] mem_port_addr_out, vexrv_data_out;

    logic [VLEN-1:0] vreg [NUM_VEC];    // model register file
    int              m_sew;             // model vsew
    logic [96:0]     exp_q [$];         // {is_store, addr, data} in program order
    logic [15:0]     lfsr = 16'd84;
    logic [5:0]      ops [5] = '{F6_VADD, F6_VSUB, F6_VAND, F6_VOR, F6_VXOR};
    int              cycles, stalls, n_sent, mism_errs, other_errs;

    rvv_proc dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};   // one step per bit
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    // low element of v copied into every lane, w = 64 shifts the 1 out so mask is all ones
    function automatic logic [63:0] splat_lanes(input logic [63:0] v, input int s);
        logic [63:0] m, r;
        m = (64'd1 << (8 << s)) - 64'd1;
        r = '0;
        for (int e = 0; e < 64; e += (8 << s))
            r = r | ((v & m) << e);
        return r;
    endfunction

    // element by element, b is vs2 and a the first operand
    function automatic logic [63:0] lane_alu(input logic [5:0] f6, input logic [63:0] a,
                                             input logic [63:0] b, input int s);
        logic [63:0] m, r, ea, eb;
        m = (64'd1 << (8 << s)) - 64'd1;
        r = '0;
        for (int e = 0; e < 64; e += (8 << s)) begin
            ea = (a >> e) & m;
            eb = (b >> e) & m;
            case (f6)
                F6_VADD: r = r | (((eb + ea) & m) << e);   // carry dropped at lane top
                F6_VSUB: r = r | (((eb - ea) & m) << e);
                F6_VAND: r = r | ((eb & ea) << e);
                F6_VOR:  r = r | ((eb | ea) << e);
                default: r = r | ((eb ^ ea) << e);
            endcase
        end
        return r;
    endfunction

    // called on a falling edge, holds the word until the fetch register takes it
    task automatic send(input logic [31:0] word, input logic [31:0] scal);
        insn_in         = word;
        vexrv_data_in_1 = scal;
        insn_valid      = 1'b1;
        n_sent++;
        while (!proc_rdy) begin
            stalls++;
            @(negedge clk);
        end
        @(negedge clk);                  // accepted at the rising edge just passed
        insn_valid = 1'b0;
    endtask

    task automatic run_op(input logic [5:0] f6, input logic [2:0] f3, input logic [4:0] vd,
                          input logic [4:0] vs2, input logic [4:0] vs1, input logic [31:0] x);
        insn_t       i;
        logic [63:0] opa;
        if (f3 == F3_IVV)
            opa = vreg[vs1];
        else if (f3 == F3_IVI)
            opa = splat_lanes({{59{vs1[4]}}, vs1}, m_sew);     // simm5
        else
            opa = splat_lanes({{32{x[31]}}, x}, m_sew);
        vreg[vd] = lane_alu(f6, opa, vreg[vs2], m_sew);
        i.alu = '{f6, 1'b1, vs2, vs1, f3, vd, OPC_OPV};
        send(i, x);
    endtask

    task automatic store_reg(input logic [4:0] vs3);
        insn_t       i;
        logic [31:0] addr;
        addr = rand_bits(32);
        exp_q.push_back({1'b1, addr, vreg[vs3]});
        i.alu = '{6'b000000, 1'b1, 5'd0, 5'd10, 3'b111, vs3, OPC_STORE};   // unit stride
        send(i, addr);
    endtask

    task automatic set_vtype(input int s, input logic [4:0] rs1, input logic [31:0] avl);
        insn_t       i;
        logic [31:0] vlmax;
        logic [31:0] exp_vl;
        vlmax  = VLEN / (8 << s);        // elements of sew bits in one register
        exp_vl = (rs1 == 5'd0) ? vlmax : ((avl < vlmax) ? avl : vlmax);
        m_sew  = s;
        exp_q.push_back({1'b0, 32'h0, 32'h0, exp_vl});
        i.cfg = '{1'b0, {5'b0, 3'(s), 3'b000}, rs1, F3_CFG, 5'd10, OPC_OPV};
        send(i, avl);
    endtask

    // pops the oldest expectation, so a strobe out of order shows up here
    task automatic check_strobe(input logic is_st, input logic [63:0] data,
                                input logic [31:0] addr);
        logic [96:0] e;
        logic        ok;
        ok = exp_q.size() > 0;
        if (ok)
            ok = exp_q[0][96] == is_st;
        assert (ok) else begin
            other_errs++;
            $display("%s strobe arrived when it was not the next expected output",
                     is_st ? "store" : "vl");
        end
        if (ok) begin
            e = exp_q.pop_front();
            if (is_st) begin
                assert (data == e[63:0]) else begin
                    mism_errs++;
                    $display("MISMATCH mem_port_out got %h exp %h", data, e[63:0]);
                end
                assert (addr == e[95:64]) else begin
                    mism_errs++;
                    $display("MISMATCH mem_port_addr_out got %h exp %h", addr, e[95:64]);
                end
            end else begin
                assert (data[31:0] == e[31:0]) else begin
                    mism_errs++;
                    $display("MISMATCH vexrv_data_out got %h exp %h", data[31:0], e[31:0]);
                end
            end
        end
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (cycles > 0 && !rst_n) begin
            assert (!proc_rdy && !mem_port_valid_out && !vexrv_valid_out) else begin
                other_errs++;
                $display("proc_rdy or an output strobe was high during reset");
            end
        end else if (cycles > 0) begin
            if (mem_port_valid_out)      // an older store goes first on a shared cycle
                check_strobe(1'b1, mem_port_out, mem_port_addr_out);
            if (vexrv_valid_out)
                check_strobe(1'b0, 64'(vexrv_data_out), 32'h0);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run did not finish within %0d cycles, %0d outputs still pending",
                     MAX_CYCLES, exp_q.size());
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        logic [4:0] vd;
        rst_n           = 1'b0;
        insn_in         = '0;
        insn_valid      = 1'b0;
        vexrv_data_in_1 = '0;
        m_sew           = 0;
        for (int r = 0; r < NUM_VEC; r++)
            vreg[r] = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        store_reg(5'd5);                 // never written, reads back zero
        for (int s = 0; s < 4; s++) begin
            set_vtype(s, 5'd0, rand_bits(4));    // x0 asks for vlmax
            repeat (3) set_vtype(s, 5'd7, rand_bits(4));
        end

        // splat forms from v0, negative imm at sew 16 and 64, scalar msb forced once
        for (int s = 0; s < 4; s++) begin
            set_vtype(s, 5'd0, 32'd0);
            run_op(F6_VADD, F3_IVI, 5'd1, 5'd0, 5'(rand_bits(4)) ^ 5'(s << 4), 32'd0);
            store_reg(5'd1);
            run_op(F6_VADD, F3_IVX, 5'd2, 5'd0, 5'd0, rand_bits(32));
            store_reg(5'd2);
            run_op(F6_VADD, F3_IVX, 5'd3, 5'd0, 5'd0, rand_bits(32) | 32'h8000_0000);
            store_reg(5'd3);
        end

        // v1..v8 random, upper half x1 ^ sign of x2, lower half x1 ^ x2
        set_vtype(2, 5'd0, 32'd0);
        for (int r = 1; r <= 8; r++)
            run_op(F6_VADD, F3_IVX, 5'(r), 5'd0, 5'd0, rand_bits(32));
        set_vtype(3, 5'd0, 32'd0);
        for (int r = 1; r <= 8; r++)
            run_op(F6_VXOR, F3_IVX, 5'(r), 5'(r), 5'd0, rand_bits(32));

        for (int s = 0; s < 4; s++) begin
            set_vtype(s, 5'd0, 32'd0);
            foreach (ops[k]) begin
                vd = 5'(16 + rand_bits(4));
                run_op(ops[k], F3_IVV, vd, 5'(1 + rand_bits(3)), 5'(1 + rand_bits(3)), 32'd0);
                store_reg(vd);
            end
        end

        // dependent chain, each op reads the one before
        set_vtype(0, 5'd0, 32'd0);
        run_op(F6_VADD, F3_IVI, 5'd9, 5'd0, 5'h1f, 32'd0);     // all ones
        set_vtype(1, 5'd0, 32'd0);
        stalls = 0;                      // only read after write waits from here on
        run_op(F6_VADD, F3_IVI, 5'd10, 5'd9, 5'd1, 32'd0);    // each lane wraps to 0
        run_op(F6_VSUB, F3_IVV, 5'd11, 5'd10, 5'd9, 32'd0);   // v10 - v9
        run_op(F6_VXOR, F3_IVV, 5'd12, 5'd11, 5'd9, 32'd0);
        store_reg(5'd12);
        assert (stalls > 0) else begin
            other_errs++;
            $display("proc_rdy never went low during the dependent chain");
        end
        set_vtype(2, 5'd3, 32'd1);       // vl reply right behind a store
        store_reg(5'd10);
        store_reg(5'd11);

        while (exp_q.size() != 0)
            @(negedge clk);
        repeat (6) @(negedge clk);       // room for a stray late strobe
        $display("%0d instructions, %0d cycles, %0d mismatches, %0d other errors",
                 n_sent, cycles, mism_errs, other_errs);
        if (mism_errs + other_errs == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- hdl/rvv_proc.sv
`timescale 1ns/10ps

module rvv_proc import rvv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [31:0]     insn_in,
    input  logic            insn_valid,
    input  logic [XLEN-1:0] vexrv_data_in_1,
    output logic            proc_rdy,
    output logic            mem_port_valid_out,
    output logic [VLEN-1:0] mem_port_out,
    output logic [XLEN-1:0] mem_port_addr_out,
    output logic            vexrv_valid_out,
    output logic [XLEN-1:0] vexrv_data_out
);
    // issue -> regfile
    logic [VADDR_W-1:0] rd_addr_1, rd_addr_2;
    logic [VLEN-1:0]    rd_data_1, rd_data_2;
    // issue -> execute
    logic               op_valid, st_valid;
    logic [5:0]         funct6;
    logic [2:0]         funct3;
    logic [VADDR_W-1:0] dest;
    sew_t               sew;
    logic [VLEN-1:0]    opnd_word;
    logic [XLEN-1:0]    st_addr;
    // execute -> regfile and scoreboard
    logic               wr_en;
    logic [VADDR_W-1:0] wr_addr;
    logic [VLEN-1:0]    wr_data;

    insn_issue u_issue (
        .clk(clk), .rst_n(rst_n),
        .insn_in(insn_in), .insn_valid(insn_valid), .vexrv_data_in_1(vexrv_data_in_1),
        .wr_en(wr_en), .wr_addr(wr_addr), .proc_rdy(proc_rdy),
        .rd_addr_1(rd_addr_1), .rd_addr_2(rd_addr_2),
        .op_valid(op_valid), .st_valid(st_valid), .funct6(funct6), .funct3(funct3),
        .dest(dest), .sew(sew), .opnd_word(opnd_word), .st_addr(st_addr),
        .vexrv_valid_out(vexrv_valid_out), .vexrv_data_out(vexrv_data_out)
    );

    vec_regfile u_regfile (
        .clk(clk), .rst_n(rst_n),
        .rd_addr_1(rd_addr_1), .rd_addr_2(rd_addr_2),
        .wr_addr(wr_addr), .wr_en(wr_en), .wr_data(wr_data),
        .rd_data_1(rd_data_1), .rd_data_2(rd_data_2)
    );

    vec_exec u_exec (
        .clk(clk), .rst_n(rst_n),
        .op_valid(op_valid), .st_valid(st_valid), .funct6(funct6), .funct3(funct3),
        .dest(dest), .sew(sew), .opnd_word(opnd_word), .st_addr(st_addr),
        .rd_data_1(rd_data_1), .rd_data_2(rd_data_2),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .mem_port_valid_out(mem_port_valid_out), .mem_port_out(mem_port_out),
        .mem_port_addr_out(mem_port_addr_out)
    );

endmodule

//--- hdl/vec_exec.sv
`timescale 1ns/10ps

module vec_exec import rvv_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               op_valid,
    input  logic               st_valid,
    input  logic [5:0]         funct6,
    input  logic [2:0]         funct3,
    input  logic [VADDR_W-1:0] dest,
    input  sew_t               sew,
    input  logic [VLEN-1:0]    opnd_word,      // splatted imm or scalar
    input  logic [XLEN-1:0]    st_addr,
    input  logic [VLEN-1:0]    rd_data_1,      // vs1 or vs3
    input  logic [VLEN-1:0]    rd_data_2,      // vs2
    output logic               wr_en,
    output logic [VADDR_W-1:0] wr_addr,
    output logic [VLEN-1:0]    wr_data,
    output logic               mem_port_valid_out,
    output logic [VLEN-1:0]    mem_port_out,
    output logic [XLEN-1:0]    mem_port_addr_out
);
    logic [VLEN-1:0] opa;       // first operand
    logic [VLEN-1:0] alu_res;

    // byte wide ripple, carry chain restarts at each lane boundary
    // sub computes b - a as b + ~a + 1 within every lane
    function automatic logic [VLEN-1:0] lane_addsub(
        input logic [VLEN-1:0] a,
        input logic [VLEN-1:0] b,
        input logic            sub,
        input sew_t            s
    );
        logic [VLEN-1:0] a_x;
        logic [VLEN-1:0] res;
        logic [8:0]      part;
        logic            c;
        a_x = sub ? ~a : a;
        c   = sub;
        res = '0;
        for (int i = 0; i < VLEN / 8; i++) begin
            if ((i & ((1 << s) - 1)) == 0)
                c = sub;    // first byte of a lane
            part = {1'b0, b[8*i +: 8]} + {1'b0, a_x[8*i +: 8]} + {8'h00, c};
            res[8*i +: 8] = part[7:0];
            c = part[8];
        end
        return res;
    endfunction

    // vv takes vs1 from the regfile, vi and vx take the prepared word
    assign opa = (funct3 == F3_IVV) ? rd_data_1 : opnd_word;

    always_comb begin
        case (funct6)
            F6_VADD: alu_res = lane_addsub(opa, rd_data_2, 1'b0, sew);
            F6_VSUB: alu_res = lane_addsub(opa, rd_data_2, 1'b1, sew);  // vs2 - op1
            F6_VAND: alu_res = rd_data_2 & opa;
            F6_VOR:  alu_res = rd_data_2 | opa;
            F6_VXOR: alu_res = rd_data_2 ^ opa;
            default: alu_res = '0;      // issue filters everything else
        endcase
    end

    // strobes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_en              <= 1'b0;
            mem_port_valid_out <= 1'b0;
        end else begin
            wr_en              <= op_valid;
            mem_port_valid_out <= st_valid;
        end
    end

    // writeback register, also feeds the scoreboard clear
    always_ff @(posedge clk) begin
        if (op_valid) begin
            wr_addr <= dest;
            wr_data <= alu_res;
        end
    end

    // store goes straight out, whole register
    always_ff @(posedge clk) begin
        if (st_valid) begin
            mem_port_out      <= rd_data_1;
            mem_port_addr_out <= st_addr;
        end
    end

endmodule

//--- hdl/vec_regfile.sv
`timescale 1ns/10ps

module vec_regfile import rvv_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [VADDR_W-1:0] rd_addr_1,
    input  logic [VADDR_W-1:0] rd_addr_2,
    input  logic [VADDR_W-1:0] wr_addr,
    input  logic               wr_en,
    input  logic [VLEN-1:0]    wr_data,
    output logic [VLEN-1:0]    rd_data_1,
    output logic [VLEN-1:0]    rd_data_2
);
    logic [VLEN-1:0] regs [NUM_VEC];

    // registers start at zero so a store before any write returns 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_VEC; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // one cycle read, old contents on a same edge write
    // the scoreboard never lets a reader through that early
    always_ff @(posedge clk) begin
        rd_data_1 <= regs[rd_addr_1];
        rd_data_2 <= regs[rd_addr_2];
    end

endmodule

//--- hdl/insn_issue.sv
`timescale 1ns/10ps

module insn_issue import rvv_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [31:0]        insn_in,
    input  logic               insn_valid,
    input  logic [XLEN-1:0]    vexrv_data_in_1,    // avl or store address
    input  logic               wr_en,
    input  logic [VADDR_W-1:0] wr_addr,
    output logic               proc_rdy,
    output logic [VADDR_W-1:0] rd_addr_1,
    output logic [VADDR_W-1:0] rd_addr_2,
    output logic               op_valid,
    output logic               st_valid,
    output logic [5:0]         funct6,
    output logic [2:0]         funct3,
    output logic [VADDR_W-1:0] dest,
    output sew_t               sew,
    output logic [VLEN-1:0]    opnd_word,
    output logic [XLEN-1:0]    st_addr,
    output logic               vexrv_valid_out,
    output logic [XLEN-1:0]    vexrv_data_out
);
    insn_t               insn_f;       // fetch register
    logic                valid_f;
    logic [XLEN-1:0]     scal_f;       // scalar sampled with the instruction
    logic                rdy_en;       // held low until out of reset
    logic [NUM_VEC-1:0]  sb;           // one pending-write bit per register
    logic                is_arith, is_vv, is_store, is_cfg;
    logic                haz, cfg_hold, issue;
    logic                d_op, d_st;   // read stage, regfile is busy with our addresses
    logic [5:0]          d_funct6;
    logic [2:0]          d_funct3;
    logic [VADDR_W-1:0]  d_dest;
    sew_t                d_sew;
    logic [XLEN-1:0]     d_scal;
    logic [4:0]          d_imm;
    logic [VLEN-1:0]     opnd_src;     // sign extended imm or scalar before splat
    sew_t                cfg_sew;
    sew_t                new_sew;
    logic [XLEN-1:0]     vl, vlmax;

    // copy the low sew bits of val into every lane
    function automatic logic [VLEN-1:0] splat(input logic [VLEN-1:0] val, input sew_t s);
        case (s)
            SEW_8:   return {(VLEN/8){val[7:0]}};
            SEW_16:  return {(VLEN/16){val[15:0]}};
            SEW_32:  return {(VLEN/32){val[31:0]}};
            default: return val;
        endcase
    endfunction

    // decode
    assign is_arith = insn_f.alu.opcode == OPC_OPV
                   && (insn_f.alu.funct3 == F3_IVV || insn_f.alu.funct3 == F3_IVI
                       || insn_f.alu.funct3 == F3_IVX)
                   && (insn_f.alu.funct6 == F6_VADD || insn_f.alu.funct6 == F6_VSUB
                       || insn_f.alu.funct6 == F6_VAND || insn_f.alu.funct6 == F6_VOR
                       || insn_f.alu.funct6 == F6_VXOR);
    assign is_vv    = is_arith && insn_f.alu.funct3 == F3_IVV;      // only form reading vs1
    assign is_store = insn_f.alu.opcode == OPC_STORE
                   && insn_f.alu.funct6[1:0] == 2'b00;              // unit stride only
    assign is_cfg   = insn_f.cfg.opcode == OPC_OPV && insn_f.cfg.funct3 == F3_CFG
                   && !insn_f.cfg.zero && !insn_f.cfg.vtypei[5];    // vsew up to 64

    // raw hazards on sources, plus vd so a register never has two writes in flight
    assign haz = (is_vv && sb[insn_f.alu.vs1])
              || (is_arith && (sb[insn_f.alu.vs2] || sb[insn_f.alu.vd]))
              || (is_store && sb[insn_f.alu.vd]);                   // vs3
    // vl reply waits behind an older store so the strobes stay in program order
    assign cfg_hold = is_cfg && (d_st || st_valid);
    assign issue    = valid_f && !haz && !cfg_hold;
    assign proc_rdy = rdy_en && (!valid_f || issue);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdy_en  <= 1'b0;
            valid_f <= 1'b0;
        end else begin
            rdy_en <= 1'b1;
            if (proc_rdy)
                valid_f <= insn_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (proc_rdy && insn_valid) begin
            insn_f <= insn_in;
            scal_f <= vexrv_data_in_1;
        end
    end

    // set on issue, cleared by the matching writeback
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sb <= '0;
        end else begin
            if (wr_en)
                sb[wr_addr] <= 1'b0;
            if (issue && is_arith)
                sb[insn_f.alu.vd] <= 1'b1;
        end
    end

    // vsetvli runs here, lmul is fixed at 1 so vlmax is VLEN/SEW
    assign new_sew = insn_f.cfg.vtypei[5:3];
    assign vlmax   = XLEN'(VLEN / 8) >> new_sew;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_sew         <= SEW_8;
            vl              <= '0;
            vexrv_valid_out <= 1'b0;
        end else begin
            vexrv_valid_out <= issue && is_cfg;
            if (issue && is_cfg) begin
                cfg_sew <= new_sew;
                if (insn_f.cfg.rs1 == '0 || scal_f > vlmax)
                    vl <= vlmax;    // rs1 = x0 asks for the maximum
                else
                    vl <= scal_f;
            end
        end
    end

    assign vexrv_data_out = vl;

    // read stage and execute handoff strobes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            d_op     <= 1'b0;
            d_st     <= 1'b0;
            op_valid <= 1'b0;
            st_valid <= 1'b0;
        end else begin
            d_op     <= issue && is_arith;
            d_st     <= issue && is_store;
            op_valid <= d_op;
            st_valid <= d_st;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            rd_addr_1 <= is_store ? insn_f.alu.vd : insn_f.alu.vs1;  // port 1 feeds the store
            rd_addr_2 <= insn_f.alu.vs2;
            d_funct6  <= insn_f.alu.funct6;
            d_funct3  <= insn_f.alu.funct3;
            d_dest    <= insn_f.alu.vd;
            d_sew     <= cfg_sew;           // sew in force at issue travels with the op
            d_scal    <= scal_f;
            d_imm     <= insn_f.alu.vs1;
        end
    end

    // simm5 is sign extended, the scalar sign extends only when sew is 64
    assign opnd_src = (d_funct3 == F3_IVI) ? {{(VLEN-5){d_imm[4]}}, d_imm}
                                           : {{(VLEN-XLEN){d_scal[XLEN-1]}}, d_scal};

    always_ff @(posedge clk) begin
        funct6    <= d_funct6;
        funct3    <= d_funct3;
        dest      <= d_dest;
        sew       <= d_sew;
        opnd_word <= splat(opnd_src, d_sew);
        st_addr   <= d_scal;
    end

endmodule

//--- hdl/rvv_pkg.sv
package rvv_pkg;

    // datapath and register file sizes
    localparam int VLEN    = 64;    // bits per vector register
    localparam int NUM_VEC = 32;
    localparam int VADDR_W = 5;     // log2 of NUM_VEC
    localparam int XLEN    = 32;    // scalar side width

    // major opcodes
    localparam logic [6:0] OPC_OPV   = 7'h57;
    localparam logic [6:0] OPC_STORE = 7'h27;

    // minor type, carried in funct3
    localparam logic [2:0] F3_IVV = 3'h0;  // vector-vector
    localparam logic [2:0] F3_IVI = 3'h3;  // vector-immediate
    localparam logic [2:0] F3_IVX = 3'h4;  // vector-scalar
    localparam logic [2:0] F3_CFG = 3'h7;  // vsetvli and friends

    // integer alu operations kept in this unit
    localparam logic [5:0] F6_VADD = 6'b000000;
    localparam logic [5:0] F6_VSUB = 6'b000010;
    localparam logic [5:0] F6_VAND = 6'b001001;
    localparam logic [5:0] F6_VOR  = 6'b001010;
    localparam logic [5:0] F6_VXOR = 6'b001011;

    // element width, vsew field of vtype
    typedef logic [2:0] sew_t;

    localparam sew_t SEW_8  = 3'b000;
    localparam sew_t SEW_16 = 3'b001;
    localparam sew_t SEW_32 = 3'b010;
    localparam sew_t SEW_64 = 3'b011;

    // arithmetic and store view of an instruction
    // for a store the vd slot carries vs3 and funct6[1:0] is mop
    typedef struct packed {
        logic [5:0]         funct6;
        logic               vm;
        logic [VADDR_W-1:0] vs2;
        logic [VADDR_W-1:0] vs1;    // also simm5 in the immediate form
        logic [2:0]         funct3;
        logic [VADDR_W-1:0] vd;
        logic [6:0]         opcode;
    } valu_fmt_t;

    // vsetvli view
    typedef struct packed {
        logic               zero;   // must be clear for vsetvli
        logic [10:0]        vtypei; // [5:3] vsew, [2:0] vlmul (ignored here)
        logic [4:0]         rs1;
        logic [2:0]         funct3;
        logic [4:0]         rd;
        logic [6:0]         opcode;
    } vcfg_fmt_t;

    // one fetched word, read through whichever view the opcode calls for
    typedef union packed {
        valu_fmt_t alu;
        vcfg_fmt_t cfg;
    } insn_t;

endpackage
